//--- design/trig_config.svh
`ifndef TRIG_CONFIG_SVH
`define TRIG_CONFIG_SVH

// number of trigger input channels
`define TRIG_NCHAN 4

// time address width, store depth is 2**TRIG_ADDR_BITS
`define TRIG_ADDR_BITS 8

// width of one incoming trigger word
`define TRIG_WORD_BITS 16

// metadata carried with each channel trigger
`define TRIG_META_BITS 8

// latency, offset, holdoff and prescale field width
`define TRIG_CFG_BITS 16

// records held in the output FIFO
`define TRIG_FIFO_DEPTH 16

// the address sits above two unused low bits of the word
`define TRIG_ADDR_LSB 2

`endif

//--- design/trig_word_pkg.sv
package trig_word_pkg;

    `include "trig_config.svh"

    // address word: valid flag on top, time address above the two low bits
    typedef struct packed {
        logic                                                    valid;
        logic [`TRIG_WORD_BITS-2-`TRIG_ADDR_BITS-`TRIG_ADDR_LSB:0] spare;
        logic [`TRIG_ADDR_BITS-1:0]                              addr;
        logic [`TRIG_ADDR_LSB-1:0]                               unused;
    } addr_view_t;

    // metadata word: marker flag on top, metadata byte at the bottom
    typedef struct packed {
        logic                                       marker;
        logic [`TRIG_WORD_BITS-2-`TRIG_META_BITS:0] spare;
        logic [`TRIG_META_BITS-1:0]                 meta;
    } meta_view_t;

    // the same input word, read by the former as address or as metadata
    typedef union packed {
        addr_view_t addr_w;
        meta_view_t meta_w;
    } trig_word_u;

    // one-cycle trigger out of a former
    typedef struct packed {
        logic                       strobe;
        logic [`TRIG_ADDR_BITS-1:0] addr;
        logic [`TRIG_META_BITS-1:0] meta;
    } chan_trig_t;

    // one readout slot across all channels
    typedef struct packed {
        logic [`TRIG_NCHAN-1:0]                           trig;
        logic [`TRIG_NCHAN-1:0][`TRIG_META_BITS-1:0]      meta;
    } store_out_t;

    // a set bit excludes that channel from the level-two OR
    typedef logic [`TRIG_NCHAN-1:0] chan_mask_t;

endpackage

//--- design/run_cfg_pkg.sv
package run_cfg_pkg;

    `include "trig_config.svh"

    // run configuration, latched while runrst_i is high
    typedef struct packed {
        logic [`TRIG_CFG_BITS-1:0] latency;
        logic [`TRIG_CFG_BITS-1:0] offset;
        logic [`TRIG_CFG_BITS-1:0] holdoff;
        logic [`TRIG_CFG_BITS-1:0] photo_prescale;
        logic                      photo_en;
    } run_cfg_t;

    // one output FIFO entry, marker 2'b10 on top
    typedef struct packed {
        logic [1:0]                                marker;
        logic [13-`TRIG_ADDR_BITS-`TRIG_ADDR_LSB:0] pad;
        logic [`TRIG_ADDR_BITS-1:0]                addr;
        logic [`TRIG_ADDR_LSB-1:0]                 zero;
    } trig_record_t;

endpackage

//--- design/run_if.sv
`timescale 1ns/10ps
`include "trig_config.svh"

// run state from the run controller to the store and the decision logic
interface run_if;

    import run_cfg_pkg::*;

    // high from run start until runstop
    logic                       running;
    // high once the latency has expired
    logic                       readout_en;
    // slot being read out this cycle
    logic [`TRIG_ADDR_BITS-1:0] readout_addr;
    // configuration latched in reset
    run_cfg_t                   cfg;

    modport run_ctl (
        output running, readout_en, readout_addr, cfg
    );

    modport datapath (
        input running, readout_en, readout_addr, cfg
    );

endinterface

//--- design/run_control.sv
`timescale 1ns/10ps
`include "trig_config.svh"

module run_control (
    input  logic                       sysclk_i,
    input  logic                       runrst_i,
    input  logic                       runstop_i,
    input  logic [`TRIG_CFG_BITS-1:0]  trig_latency_i,
    input  logic [`TRIG_CFG_BITS-1:0]  trig_offset_i,
    input  logic [`TRIG_CFG_BITS-1:0]  trig_holdoff_i,
    input  logic [`TRIG_CFG_BITS-1:0]  photo_prescale_i,
    input  logic                       photo_en_i,
    output logic [`TRIG_ADDR_BITS-1:0] current_address_o,
    run_if.run_ctl                     run
);

    import run_cfg_pkg::*;

    // armed during reset, fires the run on the first edge after it
    logic                      start_pend;
    // running cycles so far, stops at the latched latency
    logic [`TRIG_CFG_BITS-1:0] lat_cnt;

    // run level
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            start_pend  <= 1'b1;
            run.running <= 1'b0;
        end else if (runstop_i) begin
            start_pend  <= 1'b0;
            run.running <= 1'b0;
        end else if (start_pend) begin
            start_pend  <= 1'b0;
            run.running <= 1'b1;
        end
    end

    // configuration only follows the inputs while in reset
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            run.cfg.latency        <= trig_latency_i;
            run.cfg.offset         <= trig_offset_i;
            run.cfg.holdoff        <= trig_holdoff_i;
            run.cfg.photo_prescale <= photo_prescale_i;
            run.cfg.photo_en       <= photo_en_i;
        end
    end

    always_ff @(posedge sysclk_i) begin
        // latency count restarts whenever the run is down
        if (runrst_i || !run.running) begin
            lat_cnt <= '0;
        end else if (lat_cnt < run.cfg.latency) begin
            lat_cnt <= lat_cnt + 1'b1;
        end
        // readout opens once the count reaches the latency
        if (runrst_i || runstop_i) begin
            run.readout_en <= 1'b0;
        end else if (run.running && lat_cnt == run.cfg.latency) begin
            run.readout_en <= 1'b1;
        end
        // readout pointer starts at 0 in the first readout cycle
        if (!run.readout_en) begin
            run.readout_addr <= '0;
        end else begin
            run.readout_addr <= run.readout_addr + 1'b1;
        end
        // write-side time, 1 in the first running cycle
        if (!run.running) begin
            current_address_o <= {{(`TRIG_ADDR_BITS-1){1'b0}}, 1'b1};
        end else begin
            current_address_o <= current_address_o + 1'b1;
        end
    end

endmodule

//--- design/trig_former.sv
`timescale 1ns/10ps
`include "trig_config.svh"

module trig_former (
    input  logic                     sysclk_i,
    input  logic                     runrst_i,
    input  trig_word_pkg::trig_word_u word_i,
    input  logic                     word_valid_i,
    output trig_word_pkg::chan_trig_t trig_o
);

    import trig_word_pkg::*;

    // address word seen, waiting for the metadata word
    logic                       pending;
    // address held until the metadata arrives
    logic [`TRIG_ADDR_BITS-1:0] addr_q;
    // a new trigger starts on a valid word with the flag set
    logic                       addr_word;
    // the word after an address word is the metadata
    logic                       meta_word;

    assign addr_word = word_valid_i && !pending && word_i.addr_w.valid;
    assign meta_word = word_valid_i && pending;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            pending      <= 1'b0;
            trig_o.strobe <= 1'b0;
        end else begin
            // strobe lands one cycle after the metadata sample
            trig_o.strobe <= meta_word;
            if (addr_word) begin
                pending <= 1'b1;
            end else if (meta_word) begin
                pending <= 1'b0;
            end
        end
        // address view of the first word
        if (addr_word) begin
            addr_q <= word_i.addr_w.addr;
        end
        // metadata view of the second word
        if (meta_word) begin
            trig_o.addr <= addr_q;
            trig_o.meta <= word_i.meta_w.meta;
        end
    end

endmodule

//--- design/trig_store.sv
`timescale 1ns/10ps
`include "trig_config.svh"

module trig_store (
    input  logic                      sysclk_i,
    input  logic                      runrst_i,
    input  trig_word_pkg::chan_trig_t chan_trig_i [`TRIG_NCHAN],
    run_if.datapath                   run,
    output trig_word_pkg::store_out_t slot_o,
    output logic                      slot_valid_o
);

    import trig_word_pkg::*;

    localparam int DEPTH = 1 << `TRIG_ADDR_BITS;

    // slot data follows the read edge by one cycle
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            slot_valid_o <= 1'b0;
        end else begin
            slot_valid_o <= run.readout_en;
        end
    end

    for (genvar c = 0; c < `TRIG_NCHAN; c++) begin : g_chan
        // trigger flags per address, reset clears the whole store
        logic [DEPTH-1:0]           trig_bits;
        // metadata per address
        logic [`TRIG_META_BITS-1:0] meta_mem [DEPTH];
        // registered read data
        logic                       trig_q;
        logic [`TRIG_META_BITS-1:0] meta_q;
        // triggers are only stored while the run is up
        logic                       wr_en;

        assign wr_en = run.running && chan_trig_i[c].strobe;

        always_ff @(posedge sysclk_i) begin
            if (runrst_i) begin
                trig_bits <= '0;
            end else begin
                // read clears the slot, a same-cycle write overrides it
                if (run.readout_en) begin
                    trig_bits[run.readout_addr] <= 1'b0;
                end
                if (wr_en) begin
                    trig_bits[chan_trig_i[c].addr] <= 1'b1;
                end
            end
            if (wr_en) begin
                meta_mem[chan_trig_i[c].addr] <= chan_trig_i[c].meta;
            end
            if (run.readout_en) begin
                trig_q <= trig_bits[run.readout_addr];
                meta_q <= meta_mem[run.readout_addr];
            end
        end

        assign slot_o.trig[c] = trig_q;
        assign slot_o.meta[c] = meta_q;
    end

endmodule

//--- design/trig_decision.sv
`timescale 1ns/10ps
`include "trig_config.svh"

module trig_decision (
    input  logic                        sysclk_i,
    input  logic                        runrst_i,
    input  trig_word_pkg::store_out_t   slot_i,
    input  logic                        slot_valid_i,
    input  trig_word_pkg::chan_mask_t   trigmask_i,
    input  logic                        trigmask_update_i,
    run_if.datapath                     run,
    output run_cfg_pkg::trig_record_t   rec_o,
    output logic                        rec_push_o,
    output logic                        holdoff_o,
    output logic                        photoshutter_o
);

    import trig_word_pkg::*;
    import run_cfg_pkg::*;

    // excluded channels, everything excluded out of reset
    chan_mask_t                 mask_q;
    // address of the slot now on slot_i
    logic [`TRIG_ADDR_BITS-1:0] slot_addr;
    // cycles of holdoff still to go
    logic [`TRIG_CFG_BITS-1:0]  hold_cnt;
    // level-two triggers since the last shutter pulse
    logic [`TRIG_CFG_BITS-1:0]  photo_cnt;
    // masked OR of the slot, gated by holdoff
    logic                       fire;

    assign fire      = slot_valid_i && |(slot_i.trig & ~mask_q) && (hold_cnt == '0);
    assign holdoff_o = (hold_cnt != '0);

    // the store reads one edge before its data shows up
    always_ff @(posedge sysclk_i) begin
        slot_addr <= run.readout_addr;
        if (fire) begin
            rec_o <= '{marker: 2'b10, pad: '0, zero: '0,
                       addr: slot_addr - run.cfg.offset[`TRIG_ADDR_BITS-1:0]};
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            mask_q         <= '1;
            rec_push_o     <= 1'b0;
            hold_cnt       <= '0;
            photo_cnt      <= '0;
            photoshutter_o <= 1'b0;
        end else begin
            if (trigmask_update_i) begin
                mask_q <= trigmask_i;
            end
            rec_push_o <= fire;
            // holdoff loads on a trigger and then counts down
            if (fire) begin
                hold_cnt <= run.cfg.holdoff;
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
            // shutter on every (prescale+1)-th trigger
            photoshutter_o <= 1'b0;
            if (!run.cfg.photo_en) begin
                photo_cnt <= '0;
            end else if (fire) begin
                if (photo_cnt == run.cfg.photo_prescale) begin
                    photo_cnt      <= '0;
                    photoshutter_o <= 1'b1;
                end else begin
                    photo_cnt <= photo_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- design/trig_fifo.sv
`timescale 1ns/10ps
`include "trig_config.svh"

module trig_fifo (
    input  logic                      sysclk_i,
    input  logic                      runrst_i,
    input  run_cfg_pkg::trig_record_t rec_i,
    input  logic                      push_i,
    output run_cfg_pkg::trig_record_t tdata_o,
    output logic                      tvalid_o,
    input  logic                      tready_i
);

    import run_cfg_pkg::*;

    localparam int PTR_BITS = $clog2(`TRIG_FIFO_DEPTH);

    trig_record_t        mem [`TRIG_FIFO_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    // entries held, one bit wider than the pointers
    logic [PTR_BITS:0]   count;
    logic                do_push;
    logic                do_pop;

    // a push into a full FIFO is dropped
    assign do_push  = push_i && (count != `TRIG_FIFO_DEPTH);
    assign do_pop   = tvalid_o && tready_i;
    assign tvalid_o = (count != '0);
    // head stays put until it is popped
    assign tdata_o  = mem[rd_ptr];

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
        if (do_push) begin
            mem[wr_ptr] <= rec_i;
        end
    end

endmodule

//--- design/trig_process_top.sv
`timescale 1ns/10ps
`include "trig_config.svh"

module trig_process_top (
    input  logic                                     sysclk_i,
    input  logic                                     runrst_i,
    input  logic                                     runstop_i,
    input  logic [`TRIG_NCHAN*`TRIG_WORD_BITS-1:0]   trigin_dat_i,
    input  logic                                     trigin_valid_i,
    input  logic [`TRIG_NCHAN-1:0]                   trigmask_i,
    input  logic                                     trigmask_update_i,
    input  logic [`TRIG_CFG_BITS-1:0]                trig_latency_i,
    input  logic [`TRIG_CFG_BITS-1:0]                trig_offset_i,
    input  logic [`TRIG_CFG_BITS-1:0]                trig_holdoff_i,
    input  logic [`TRIG_CFG_BITS-1:0]                photo_prescale_i,
    input  logic                                     photo_en_i,
    output logic [15:0]                              trigout_tdata_o,
    output logic                                     trigout_tvalid_o,
    input  logic                                     trigout_tready_i,
    output logic                                     photoshutter_o,
    output logic                                     gpo_trig_d_o,
    output logic [`TRIG_NCHAN-1:0]                   scal_trig_o,
    output logic                                     running_o,
    output logic [`TRIG_ADDR_BITS-1:0]               current_address_o
);

    import trig_word_pkg::*;
    import run_cfg_pkg::*;

    run_if        run_bus ();
    chan_trig_t   chan_trig [`TRIG_NCHAN];
    store_out_t   slot;
    logic         slot_valid;
    trig_record_t rec;
    logic         rec_push;

    // one former per channel word, strobes also feed the scalers
    for (genvar c = 0; c < `TRIG_NCHAN; c++) begin : g_former
        trig_former u_former (
            .sysclk_i, .runrst_i,
            .word_i       (trigin_dat_i[c*`TRIG_WORD_BITS +: `TRIG_WORD_BITS]),
            .word_valid_i (trigin_valid_i),
            .trig_o       (chan_trig[c])
        );
        assign scal_trig_o[c] = chan_trig[c].strobe;
    end

    run_control u_run_control (
        .sysclk_i, .runrst_i, .runstop_i, .trig_latency_i, .trig_offset_i,
        .trig_holdoff_i, .photo_prescale_i, .photo_en_i, .current_address_o,
        .run (run_bus.run_ctl)
    );

    trig_store u_store (
        .sysclk_i, .runrst_i, .chan_trig_i (chan_trig), .run (run_bus.datapath),
        .slot_o (slot), .slot_valid_o (slot_valid)
    );

    trig_decision u_decision (
        .sysclk_i, .runrst_i, .slot_i (slot), .slot_valid_i (slot_valid),
        .trigmask_i, .trigmask_update_i, .run (run_bus.datapath),
        .rec_o (rec), .rec_push_o (rec_push), .holdoff_o (gpo_trig_d_o), .photoshutter_o
    );

    trig_fifo u_fifo (
        .sysclk_i, .runrst_i, .rec_i (rec), .push_i (rec_push),
        .tdata_o (trigout_tdata_o), .tvalid_o (trigout_tvalid_o), .tready_i (trigout_tready_i)
    );

    assign running_o = run_bus.running;

endmodule

//--- tb/trig_process_properties.sv
`timescale 1ns/10ps

module trig_process_properties (
    input logic                      sysclk_i,
    input logic                      runrst_i,
    input run_cfg_pkg::trig_record_t tdata_i,
    input logic                      tvalid_i,
    input logic                      tready_i,
    input logic                      photoshutter_i
);

    // assertion failures so far
    int n_fail = 0;

    // head record holds while the consumer stalls
    tdata_hold: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        tvalid_i && !tready_i |=> tvalid_i && $stable(tdata_i))
        else begin
            $error("record changed or tvalid dropped while tready was low");
            n_fail++;
        end

    // every record leaves with marker 10 on top
    marker_ok: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        tvalid_i |-> tdata_i.marker == 2'b10)
        else begin
            $error("record marker bits are not 10");
            n_fail++;
        end

    // shutter is a single-cycle pulse
    shutter_pulse: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        photoshutter_i |=> !photoshutter_i)
        else begin
            $error("photoshutter_o high for two cycles in a row");
            n_fail++;
        end

endmodule

bind trig_process_top trig_process_properties u_props (
    .sysclk_i (sysclk_i), .runrst_i (runrst_i), .tdata_i (trigout_tdata_o),
    .tvalid_i (trigout_tvalid_o), .tready_i (trigout_tready_i),
    .photoshutter_i (photoshutter_o)
);

//--- tb/trig_process_tb.sv
`timescale 1ns/10ps
`include "trig_config.svh"

module trig_process_tb;

    import trig_word_pkg::*;
    import run_cfg_pkg::*;

    localparam int LATENCY = 20;
    localparam int OFFSET  = 5;
    // cycles after the last slot until its record has surely left the pipeline
    localparam logic [`TRIG_ADDR_BITS-1:0] DRAIN = `TRIG_ADDR_BITS'(LATENCY + 16);
    localparam int TIMEOUT = 600;

    logic                                   sysclk_i;
    logic                                   runrst_i;
    logic                                   runstop_i;
    logic [`TRIG_NCHAN*`TRIG_WORD_BITS-1:0] trigin_dat_i;
    logic                                   trigin_valid_i;
    chan_mask_t                             trigmask_i;
    logic                                   trigmask_update_i;
    logic [`TRIG_CFG_BITS-1:0]              trig_latency_i;
    logic [`TRIG_CFG_BITS-1:0]              trig_offset_i;
    logic [`TRIG_CFG_BITS-1:0]              trig_holdoff_i;
    logic [`TRIG_CFG_BITS-1:0]              photo_prescale_i;
    logic                                   photo_en_i;
    logic [15:0]                            trigout_tdata_o;
    logic                                   trigout_tvalid_o;
    logic                                   trigout_tready_i;
    logic                                   photoshutter_o;
    logic                                   gpo_trig_d_o;
    logic [`TRIG_NCHAN-1:0]                 scal_trig_o;
    logic                                   running_o;
    logic [`TRIG_ADDR_BITS-1:0]             current_address_o;

    // records taken off the output, shutter pulses and holdoff cycles seen, error counts
    trig_record_t rec_q [$];
    int           n_photo;
    int           n_hold;
    int           n_checks;
    int           n_err;
    int           n_timeout;

    trig_process_top dut (.*);

    initial begin
        sysclk_i = 1'b0;
        forever #10 sysclk_i = ~sysclk_i;
    end

    task automatic check_record(input trig_record_t got, input trig_record_t exp,
                                input string what);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("** Error at %0t ns: %s record %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_strobes(input logic [`TRIG_NCHAN-1:0] got,
                                 input logic [`TRIG_NCHAN-1:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input logic [`TRIG_ADDR_BITS-1:0] got,
                              input logic [`TRIG_ADDR_BITS-1:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        n_checks++;
        if (got != exp) begin
            n_err++;
            $display("** Error at %0t ns: %s count %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // record for a slot: marker 10, address minus offset, zero low bits
    function automatic trig_record_t expect_rec(input logic [`TRIG_ADDR_BITS-1:0] slot);
        trig_record_t r;
        r        = '0;
        r.marker = 2'b10;
        r.addr   = slot - `TRIG_ADDR_BITS'(OFFSET);
        return r;
    endfunction

    // reset latches the config, then wait for the run to come up
    task automatic apply_reset(input logic [`TRIG_CFG_BITS-1:0] holdoff,
                               input logic [`TRIG_CFG_BITS-1:0] prescale,
                               input logic photo_en);
        int waited;
        @(negedge sysclk_i);
        trig_latency_i   = LATENCY;
        trig_offset_i    = OFFSET;
        trig_holdoff_i   = holdoff;
        photo_prescale_i = prescale;
        photo_en_i       = photo_en;
        runstop_i        = 1'b0;
        runrst_i         = 1'b1;
        repeat (8) @(negedge sysclk_i);
        check_level(running_o, 1'b0, "running_o in reset");
        check_level(trigout_tvalid_o, 1'b0, "tvalid in reset");
        check_level(photoshutter_o, 1'b0, "photoshutter_o in reset");
        check_level(gpo_trig_d_o, 1'b0, "gpo_trig_d_o in reset");
        check_strobes(scal_trig_o, '0, "scal_trig_o in reset");
        runrst_i = 1'b0;
        waited   = 0;
        while (!running_o && waited < TIMEOUT) begin
            @(negedge sysclk_i);
            waited++;
        end
        if (!running_o) begin
            n_timeout++;
            $display("timeout: running_o never rose after reset");
        end else begin
            // running_o rises on the first edge after reset drops
            check_count(waited, 1, "edges from reset release to running_o");
        end
        rec_q.delete();
        n_photo = 0;
        n_hold  = 0;
    endtask

    task automatic set_mask(input chan_mask_t m);
        @(negedge sysclk_i);
        trigmask_i        = m;
        trigmask_update_i = 1'b1;
        @(negedge sysclk_i);
        trigmask_update_i = 1'b0;
    endtask

    // address word then metadata word on one channel
    task automatic send_trig(input int ch, input logic [7:0] addr, input logic [7:0] meta);
        logic [`TRIG_NCHAN-1:0] onehot;
        onehot     = '0;
        onehot[ch] = 1'b1;
        @(negedge sysclk_i);
        trigin_valid_i = 1'b1;
        trigin_dat_i   = '0;
        trigin_dat_i[ch*`TRIG_WORD_BITS +: `TRIG_WORD_BITS] = {1'b1, 5'b0, addr, 2'b00};
        @(negedge sysclk_i);
        // the address word alone raises no strobe
        check_strobes(scal_trig_o, '0, "scal_trig_o after address word");
        trigin_dat_i[ch*`TRIG_WORD_BITS +: `TRIG_WORD_BITS] = {8'h00, meta};
        @(negedge sysclk_i);
        // strobe one cycle after the metadata sample
        check_strobes(scal_trig_o, onehot, "scal_trig_o after metadata word");
        trigin_valid_i = 1'b0;
        trigin_dat_i   = '0;
    endtask

    // take records, count shutter pulses and holdoff cycles until the write time reaches target
    task automatic collect_until(input logic [`TRIG_ADDR_BITS-1:0] target);
        int waited;
        waited = 0;
        while (current_address_o != target && waited < TIMEOUT) begin
            if (trigout_tvalid_o && trigout_tready_i) begin
                rec_q.push_back(trigout_tdata_o);
            end
            if (photoshutter_o) begin
                n_photo++;
            end
            if (gpo_trig_d_o) begin
                n_hold++;
            end
            @(negedge sysclk_i);
            waited++;
        end
        if (current_address_o != target) begin
            n_timeout++;
            $display("timeout: current address never reached %0d", target);
        end
    endtask

    task automatic test_run_start();
        logic [`TRIG_ADDR_BITS-1:0] prev;
        apply_reset(0, 0, 1'b0);
        check_addr(current_address_o, 1, "first running address");
        repeat (5) begin
            prev = current_address_o;
            @(negedge sysclk_i);
            check_addr(current_address_o, prev + 1'b1, "current_address_o step");
        end
        runstop_i = 1'b1;
        @(negedge sysclk_i);
        runstop_i = 1'b0;
        check_level(running_o, 1'b0, "running_o after runstop");
    endtask

    task automatic test_single();
        int         ch;
        logic [7:0] a;
        ch = $urandom % `TRIG_NCHAN;
        apply_reset(0, 0, 1'b0);
        set_mask(~(chan_mask_t'(1) << ch));
        a = current_address_o + 8'd40;
        send_trig(ch, a, 8'($urandom));
        collect_until(a + DRAIN);
        check_count(rec_q.size(), 1, "single trigger");
        if (rec_q.size() > 0) begin
            check_record(rec_q[0], expect_rec(a), "single trigger");
        end
    endtask

    task automatic test_mask();
        int         ch;
        logic [7:0] a;
        logic [7:0] meta;
        ch   = $urandom % `TRIG_NCHAN;
        meta = 8'($urandom);
        apply_reset(0, 0, 1'b0);
        set_mask('1);
        a = current_address_o + 8'd40;
        send_trig(ch, a, meta);
        collect_until(a + DRAIN);
        check_count(rec_q.size(), 0, "masked channel");
        // same trigger once the channel is let through
        set_mask(~(chan_mask_t'(1) << ch));
        a = current_address_o + 8'd40;
        send_trig(ch, a, meta);
        collect_until(a + DRAIN);
        check_count(rec_q.size(), 1, "unmasked channel");
        if (rec_q.size() > 0) begin
            check_record(rec_q[0], expect_rec(a), "unmasked channel");
        end
    endtask

    task automatic test_holdoff();
        int         ch;
        logic [7:0] a;
        ch = $urandom % `TRIG_NCHAN;
        apply_reset(10, 0, 1'b0);
        set_mask('0);
        a = current_address_o + 8'd40;
        send_trig(ch, a, 8'($urandom));
        // inside the holdoff window, ignored
        send_trig(ch, a + 8'd2, 8'($urandom));
        send_trig(ch, a + 8'd40, 8'($urandom));
        collect_until(a + 8'd40 + DRAIN);
        check_count(rec_q.size(), 2, "holdoff");
        if (rec_q.size() == 2) begin
            check_record(rec_q[0], expect_rec(a), "holdoff first");
            check_record(rec_q[1], expect_rec(a + 8'd40), "holdoff second");
        end
        // two level-two triggers, each followed by ten holdoff cycles
        check_count(n_hold, 2 * 10, "gpo_trig_d_o holdoff cycles");
    endtask

    task automatic test_backpressure();
        logic [7:0] a;
        apply_reset(0, 0, 1'b0);
        set_mask('0);
        trigout_tready_i = 1'b0;
        a = current_address_o + 8'd40;
        for (int i = 0; i < 3; i++) begin
            send_trig($urandom % `TRIG_NCHAN, a + 8'(i * 20), 8'($urandom));
        end
        collect_until(a + 8'd40 + DRAIN);
        check_level(trigout_tvalid_o, 1'b1, "tvalid while stalled");
        check_record(trigout_tdata_o, expect_rec(a), "head while stalled");
        trigout_tready_i = 1'b1;
        collect_until(current_address_o + 8'd8);
        check_count(rec_q.size(), 3, "drained records");
        for (int i = 0; i < rec_q.size() && i < 3; i++) begin
            check_record(rec_q[i], expect_rec(a + 8'(i * 20)), "drained record");
        end
        check_level(trigout_tvalid_o, 1'b0, "tvalid after drain");
    endtask

    task automatic test_photo();
        int         ch;
        logic [7:0] a;
        ch = $urandom % `TRIG_NCHAN;
        apply_reset(0, 2, 1'b1);
        set_mask('0);
        a = current_address_o + 8'd40;
        send_trig(ch, a, 8'($urandom));
        send_trig(ch, a + 8'd20, 8'($urandom));
        send_trig(ch, a + 8'd40, 8'($urandom));
        // no pulse on the first two triggers
        collect_until(a + 8'd20 + DRAIN);
        check_count(rec_q.size(), 2, "photo first two records");
        check_count(n_photo, 0, "shutter pulses before third trigger");
        collect_until(a + 8'd40 + DRAIN);
        check_count(rec_q.size(), 3, "photo records");
        check_count(n_photo, 1, "shutter pulses after third trigger");
    endtask

    initial begin
        void'($urandom(69914));
        runrst_i          = 1'b1;
        runstop_i         = 1'b0;
        trigin_dat_i      = '0;
        trigin_valid_i    = 1'b0;
        trigmask_i        = '1;
        trigmask_update_i = 1'b0;
        trig_latency_i    = LATENCY;
        trig_offset_i     = OFFSET;
        trig_holdoff_i    = '0;
        photo_prescale_i  = '0;
        photo_en_i        = 1'b0;
        trigout_tready_i  = 1'b1;
        n_checks          = 0;
        n_err             = 0;
        n_timeout         = 0;
        n_photo           = 0;
        n_hold            = 0;
        test_run_start();
        test_single();
        test_mask();
        test_holdoff();
        test_backpressure();
        test_photo();
        $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
                 n_checks, n_err, n_timeout, dut.u_props.n_fail);
        if (n_err == 0 && n_timeout == 0 && dut.u_props.n_fail == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+design
design/trig_word_pkg.sv
design/run_cfg_pkg.sv
design/run_if.sv
design/run_control.sv
design/trig_former.sv
design/trig_store.sv
design/trig_decision.sv
design/trig_fifo.sv
design/trig_process_top.sv
tb/trig_process_properties.sv
tb/trig_process_tb.sv
